// ==== Bender.yml ====
package:
  name: masked_bfu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mbfu_pkg.sv
      - rtl/bfu_stream_if.sv
      - rtl/masked_add_sub.sv
      - rtl/masked_mod_mult.sv
      - rtl/share_delay.sv
      - rtl/mask_rnd_gen.sv
      - rtl/masked_gs_butterfly.sv
      - rtl/bfu_ctrl_regs.sv
      - rtl/masked_bfu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/tb_masked_bfu.sv

// ==== bench/tb_masked_bfu.sv ====
`timescale 1ns/1ps
`include "mbfu_consts.svh"

module tb_masked_bfu;

    localparam longint Q = `MBFU_Q;
    localparam int TIMEOUT = 100;
    // accept to result, the same in every mode
    localparam int EXP_LAT = 6;

    // one operand set in shares plus the plain expected results
    typedef struct packed {
        logic [`MBFU_W-1:0] u0;
        logic [`MBFU_W-1:0] u1;
        logic [`MBFU_W-1:0] v0;
        logic [`MBFU_W-1:0] v1;
        logic [`MBFU_W-1:0] w0;
        logic [`MBFU_W-1:0] w1;
        logic [`MBFU_W-1:0] exp_u;
        logic [`MBFU_W-1:0] exp_v;
        logic               pwm;
    } op_t;

    logic               clk;
    logic               reset_n;
    logic               cfg_we_i;
    logic [1:0]         cfg_addr_i;
    logic [31:0]        cfg_wdata_i;
    logic [31:0]        cfg_rdata_o;
    logic               in_valid_i;
    logic               in_ready_o;
    logic [`MBFU_W-1:0] u0_i;
    logic [`MBFU_W-1:0] u1_i;
    logic [`MBFU_W-1:0] v0_i;
    logic [`MBFU_W-1:0] v1_i;
    logic [`MBFU_W-1:0] w0_i;
    logic [`MBFU_W-1:0] w1_i;
    logic               out_valid_o;
    logic               out_ready_i;
    logic [`MBFU_W-1:0] u0_o;
    logic [`MBFU_W-1:0] u1_o;
    logic [`MBFU_W-1:0] v0_o;
    logic [`MBFU_W-1:0] v1_o;

    logic [31:0]        rng_state;
    logic               cur_pwm;
    logic               cur_acc;
    int                 err_count;
    op_t                ops[$];
    logic [`MBFU_W-1:0] res_u0[$];
    logic [`MBFU_W-1:0] res_v0[$];

    masked_bfu_top DUT (
        .clk(clk), .reset_n(reset_n),
        .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i),
        .cfg_rdata_o(cfg_rdata_o),
        .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
        .u0_i(u0_i), .u1_i(u1_i), .v0_i(v0_i), .v1_i(v1_i), .w0_i(w0_i), .w1_i(w1_i),
        .out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
        .u0_o(u0_o), .u1_o(u1_o), .v0_o(v0_o), .v1_o(v1_o)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // xorshift32 stimulus source
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic longint rand_q();
        return next_rand() % Q;
    endfunction

    // reference arithmetic on plain values mod q
    function automatic longint mod_add(input longint a, input longint b);
        return (a + b) % Q;
    endfunction

    function automatic longint mod_sub(input longint a, input longint b);
        return (a - b + Q) % Q;
    endfunction

    function automatic longint mod_mul(input longint a, input longint b);
        return (a * b) % Q;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        if (actual !== expected) begin
            err_count++;
            $display("FAILED at time %0t: %s (got %0d, expected %0d)",
                     $time, msg, actual, expected);
            $display("Verification failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic timeout_fail(input string msg);
        err_count++;
        $display("timeout: %s", msg);
        $display("Verification failed");
        $fatal(1, "stopping on timeout");
    endtask

    // random plain operands split as r and x minus r
    // expected results follow the current mode
    task automatic gen_ops(input int n);
        op_t    op;
        longint u;
        longint v;
        longint w;
        for (int i = 0; i < n; i++) begin
            u = rand_q();
            v = rand_q();
            w = rand_q();
            op.u0 = rand_q();
            op.u1 = mod_sub(u, op.u0);
            op.v0 = rand_q();
            op.v1 = mod_sub(v, op.v0);
            op.w0 = rand_q();
            op.w1 = mod_sub(w, op.w0);
            op.pwm = cur_pwm;
            if (cur_pwm) begin
                op.exp_u = cur_acc ? mod_add(mod_mul(u, v), w) : mod_mul(u, v);
                op.exp_v = '0;
            end else begin
                op.exp_u = mod_add(u, v);
                op.exp_v = mod_mul(mod_sub(u, v), w);
            end
            ops.push_back(op);
        end
    endtask

    task automatic drive_op(input op_t op);
        in_valid_i = 1'b1;
        u0_i = op.u0;
        u1_i = op.u1;
        v0_i = op.v0;
        v1_i = op.v1;
        w0_i = op.w0;
        w1_i = op.w1;
    endtask

    // compares the current output beat against one operand set
    task automatic check_result(input op_t op);
        check_equal(mod_add(u0_o, u1_o), op.exp_u, "u share sum");
        if (op.pwm) begin
            check_equal(v0_o, 0, "v share 0 in pwm mode");
            check_equal(v1_o, 0, "v share 1 in pwm mode");
        end else begin
            check_equal(mod_add(v0_o, v1_o), op.exp_v, "v share sum");
        end
        res_u0.push_back(u0_o);
        res_v0.push_back(v0_o);
    endtask

    // all tasks start and end 1 ns after a rising edge
    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        cfg_we_i = 1'b1;
        cfg_addr_i = addr;
        cfg_wdata_i = data;
        @(posedge clk);
        #1;
        cfg_we_i = 1'b0;
        cfg_wdata_i = '0;
    endtask

    task automatic cfg_expect(input logic [1:0] addr, input logic [31:0] exp,
                              input string msg);
        cfg_addr_i = addr;
        #1;
        check_equal(cfg_rdata_o, exp, msg);
        @(posedge clk);
        #1;
    endtask

    task automatic set_mode(input logic pwm, input logic acc);
        cfg_write(`MBFU_REG_CTRL, {30'd0, acc, pwm});
        cur_pwm = pwm;
        cur_acc = acc;
    endtask

    // one operand held until accepted
    task automatic send_op(input op_t op);
        int waited;
        waited = 0;
        drive_op(op);
        @(negedge clk);
        while (!in_ready_o) begin
            waited++;
            if (waited >= TIMEOUT) begin
                timeout_fail("in_ready_o stayed low for 100 cycles");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid_i = 1'b0;
    endtask

    task automatic wait_out_valid();
        int waited;
        waited = 0;
        while (!out_valid_o) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited >= TIMEOUT) begin
                timeout_fail("out_valid_o stayed low for 100 cycles");
            end
        end
    endtask

    // streams the whole queue with optional random output back-pressure
    task automatic run_stream(input logic rand_ready);
        int          idx;
        int          got;
        int          idle;
        logic        in_acc;
        logic        out_acc;
        logic [31:0] r;
        idx = 0;
        got = 0;
        idle = 0;
        res_u0.delete();
        res_v0.delete();
        while (got < ops.size()) begin
            if (idx < ops.size()) begin
                drive_op(ops[idx]);
            end else begin
                in_valid_i = 1'b0;
            end
            r = next_rand();
            out_ready_i = rand_ready ? r[3] : 1'b1;
            // sample mid-cycle before the handshake edge
            @(negedge clk);
            in_acc = in_valid_i && in_ready_o;
            out_acc = out_valid_o && out_ready_i;
            if (out_valid_o && !out_ready_i) begin
                check_equal(in_ready_o, 0, "in_ready_o high during output stall");
            end
            if (out_acc) begin
                check_result(ops[got]);
                got++;
            end
            if (in_acc) begin
                idx++;
            end
            idle = (in_acc || out_acc) ? 0 : idle + 1;
            if (idle >= TIMEOUT) begin
                timeout_fail("no handshake on in_ready_o or out_valid_o for 100 cycles");
            end
            @(posedge clk);
            #1;
        end
        in_valid_i = 1'b0;
        out_ready_i = 1'b1;
        check_equal(out_valid_o, 0, "extra result after burst");
    endtask

    task automatic test_registers();
        check_equal(out_valid_o, 0, "out_valid_o after reset");
        cfg_expect(`MBFU_REG_CTRL, 32'd0, "ctrl after reset");
        cfg_expect(`MBFU_REG_SEED, `MBFU_SEED_DEFAULT, "seed after reset");
        cfg_write(`MBFU_REG_CTRL, 32'd3);
        cfg_expect(`MBFU_REG_CTRL, 32'd3, "ctrl readback pwm+acc");
        cfg_write(`MBFU_REG_CTRL, 32'd1);
        cfg_expect(`MBFU_REG_CTRL, 32'd1, "ctrl readback pwm");
        cfg_write(`MBFU_REG_SEED, 32'h1357_9BDF);
        cfg_expect(`MBFU_REG_SEED, 32'h1357_9BDF, "seed readback");
        set_mode(1'b0, 1'b0);
        cfg_expect(`MBFU_REG_CTRL, 32'd0, "ctrl back to gs");
    endtask

    task automatic test_gs();
        int lat;
        ops.delete();
        gen_ops(16);
        run_stream(1'b0);
        // isolated operand on an empty pipe
        ops.delete();
        gen_ops(1);
        send_op(ops[0]);
        lat = 1;
        while (!out_valid_o) begin
            @(posedge clk);
            #1;
            lat++;
            if (lat > TIMEOUT) begin
                timeout_fail("out_valid_o never rose for the isolated operand");
            end
        end
        check_equal(lat, EXP_LAT, "cycles from acceptance to result");
        check_result(ops[0]);
        @(posedge clk);
        #1;
        check_equal(out_valid_o, 0, "out_valid_o after isolated result");
    endtask

    task automatic test_pwm();
        set_mode(1'b1, 1'b0);
        ops.delete();
        gen_ops(12);
        run_stream(1'b0);
        set_mode(1'b1, 1'b1);
        ops.delete();
        gen_ops(12);
        run_stream(1'b1);
        set_mode(1'b0, 1'b0);
    endtask

    task automatic test_backpressure();
        ops.delete();
        gen_ops(24);
        run_stream(1'b1);
    endtask

    task automatic test_masking();
        ops.delete();
        gen_ops(1);
        ops.push_back(ops[0]);
        run_stream(1'b0);
        // fresh masks per slot keep identical inputs from repeating shares
        check_equal(res_u0[0] != res_u0[1], 1, "u share 0 repeated for same operand");
        check_equal(res_v0[0] != res_v0[1], 1, "v share 0 repeated for same operand");
    endtask

    task automatic test_zeroize();
        // non-default mode so the clear of ctrl shows up on readback
        set_mode(1'b1, 1'b1);
        ops.delete();
        gen_ops(3);
        out_ready_i = 1'b0;
        for (int i = 0; i < 3; i++) begin
            send_op(ops[i]);
        end
        // pipe stalls with a result parked at the output
        wait_out_valid();
        cfg_write(`MBFU_REG_ZEROIZE, 32'd1);
        @(posedge clk);
        #1;
        check_equal(out_valid_o, 0, "out_valid_o after zeroize");
        check_equal(u0_o, 0, "u0_o after zeroize");
        check_equal(u1_o, 0, "u1_o after zeroize");
        check_equal(v0_o, 0, "v0_o after zeroize");
        check_equal(v1_o, 0, "v1_o after zeroize");
        cur_pwm = 1'b0;
        cur_acc = 1'b0;
        out_ready_i = 1'b1;
        cfg_expect(`MBFU_REG_CTRL, 32'd0, "ctrl after zeroize");
        cfg_expect(`MBFU_REG_SEED, `MBFU_SEED_DEFAULT, "seed after zeroize");
        ops.delete();
        gen_ops(8);
        run_stream(1'b1);
    endtask

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        cfg_we_i = 1'b0;
        cfg_addr_i = '0;
        cfg_wdata_i = '0;
        in_valid_i = 1'b0;
        u0_i = '0;
        u1_i = '0;
        v0_i = '0;
        v1_i = '0;
        w0_i = '0;
        w1_i = '0;
        out_ready_i = 1'b1;
        rng_state = 32'd26;
        cur_pwm = 1'b0;
        cur_acc = 1'b0;
        err_count = 0;
        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;
        test_registers();
        test_gs();
        test_pwm();
        test_backpressure();
        test_masking();
        test_zeroize();
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== masked_bfu.f ====
+incdir+rtl
rtl/mbfu_pkg.sv
rtl/bfu_stream_if.sv
rtl/masked_add_sub.sv
rtl/masked_mod_mult.sv
rtl/share_delay.sv
rtl/mask_rnd_gen.sv
rtl/masked_gs_butterfly.sv
rtl/bfu_ctrl_regs.sv
rtl/masked_bfu_top.sv
bench/tb_masked_bfu.sv

// ==== rtl/bfu_ctrl_regs.sv ====
`timescale 1ns/1ps
`include "mbfu_consts.svh"

module bfu_ctrl_regs import mbfu_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        cfg_we_i,
    input  logic [1:0]  cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,
    output logic [31:0] cfg_rdata_o,
    output bfu_ctrl_t   ctrl_o,
    output logic [31:0] seed_o,
    output logic        seed_load_o,
    output logic        zeroize_o
);

    bfu_ctrl_t   ctrl_q;
    logic [31:0] seed_q;
    logic        zeroize_q;
    logic        seed_load_q;
    logic        wr_ctrl;
    logic        wr_seed;
    logic        wr_zero;

    assign wr_ctrl = cfg_we_i && (cfg_addr_i == `MBFU_REG_CTRL);
    assign wr_seed = cfg_we_i && (cfg_addr_i == `MBFU_REG_SEED);
    assign wr_zero = cfg_we_i && (cfg_addr_i == `MBFU_REG_ZEROIZE) && cfg_wdata_i[0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_q      <= '{mode: gs, accumulate: 1'b0};
            seed_q      <= `MBFU_SEED_DEFAULT;
            zeroize_q   <= 1'b0;
            seed_load_q <= 1'b0;
        end else begin
            // pulses trail the write by one edge, seed is already in place
            zeroize_q   <= wr_zero;
            seed_load_q <= wr_seed || wr_zero;
            if (wr_zero) begin
                ctrl_q <= '{mode: gs, accumulate: 1'b0};
                seed_q <= `MBFU_SEED_DEFAULT;
            end else begin
                if (wr_ctrl) begin
                    // bit 0 mode, bit 1 accumulate
                    ctrl_q.mode       <= bfu_mode_t'(cfg_wdata_i[0]);
                    ctrl_q.accumulate <= cfg_wdata_i[1];
                end
                if (wr_seed) begin
                    seed_q <= cfg_wdata_i;
                end
            end
        end
    end

    always_comb begin
        case (cfg_addr_i)
            `MBFU_REG_CTRL: cfg_rdata_o = {30'd0, ctrl_q.accumulate, ctrl_q.mode};
            `MBFU_REG_SEED: cfg_rdata_o = seed_q;
            // zeroize reads as zero
            default:        cfg_rdata_o = '0;
        endcase
    end

    assign ctrl_o      = ctrl_q;
    assign seed_o      = seed_q;
    assign seed_load_o = seed_load_q;
    assign zeroize_o   = zeroize_q;

endmodule

// ==== rtl/bfu_stream_if.sv ====
`timescale 1ns/1ps

// operand side: three masked coefficients per transfer
interface bfu_op_if import mbfu_pkg::*; ();
    logic        valid;
    logic        ready;
    share_pair_t u;
    share_pair_t v;
    share_pair_t w;

    // producer holds u/v/w steady while stalled
    modport src (output valid, output u, output v, output w, input ready);
    modport snk (input valid, input u, input v, input w, output ready);
endinterface

// result side: two masked coefficients per transfer
interface bfu_res_if import mbfu_pkg::*; ();
    logic        valid;
    logic        ready;
    share_pair_t u;
    share_pair_t v;

    modport src (output valid, output u, output v, input ready);
    modport snk (input valid, input u, input v, output ready);
endinterface

// ==== rtl/mask_rnd_gen.sv ====
`timescale 1ns/1ps
`include "mbfu_consts.svh"

module mask_rnd_gen (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    advance_i,
    input  logic                    load_i,
    input  logic [31:0]             seed_i,
    output logic [2:0][`MBFU_W-1:0] rnd_o
);

    localparam logic [31:0] SEED_D = `MBFU_SEED_DEFAULT;

    logic [31:0] st_q [3];
    logic [31:0] seed_nz;
    logic [31:0] seed_inv;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // all-zero state would lock up the generator
    assign seed_nz  = (seed_i == '0) ? SEED_D : seed_i;
    assign seed_inv = (~seed_nz == '0) ? SEED_D : ~seed_nz;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            st_q[0] <= SEED_D;
            st_q[1] <= {SEED_D[15:0], SEED_D[31:16]};
            st_q[2] <= ~SEED_D;
        end else if (load_i) begin
            // three decorrelated starting points from one seed
            st_q[0] <= seed_nz;
            st_q[1] <= {seed_nz[15:0], seed_nz[31:16]};
            st_q[2] <= seed_inv;
        end else if (advance_i) begin
            for (int i = 0; i < 3; i++) begin
                st_q[i] <= xorshift32(st_q[i]);
            end
        end
    end

    // fold low bits into [0, q)
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            rnd_o[i] = (st_q[i][`MBFU_W-1:0] >= `MBFU_Q) ?
                       st_q[i][`MBFU_W-1:0] - `MBFU_Q : st_q[i][`MBFU_W-1:0];
        end
    end

endmodule

// ==== rtl/masked_add_sub.sv ====
`timescale 1ns/1ps
`include "mbfu_consts.svh"

module masked_add_sub import mbfu_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               en_i,
    input  logic               zeroize_i,
    input  logic               sub_i,
    input  share_pair_t        a_i,
    input  share_pair_t        b_i,
    input  logic [`MBFU_W-1:0] rnd_i,
    output share_pair_t        res_o
);

    share_pair_t sum_q;
    share_pair_t res_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_q <= '0;
            res_q <= '0;
        end else if (zeroize_i) begin
            sum_q <= '0;
            res_q <= '0;
        end else if (en_i) begin
            // stage 1: share-wise, each domain stays on its own
            if (sub_i) begin
                sum_q.s0 <= sub_mod(a_i.s0, b_i.s0);
                sum_q.s1 <= sub_mod(a_i.s1, b_i.s1);
            end else begin
                sum_q.s0 <= add_mod(a_i.s0, b_i.s0);
                sum_q.s1 <= add_mod(a_i.s1, b_i.s1);
            end
            // stage 2: remask, +r on one side and -r on the other
            res_q.s0 <= add_mod(sum_q.s0, rnd_i);
            res_q.s1 <= sub_mod(sum_q.s1, rnd_i);
        end
    end

    assign res_o = res_q;

endmodule

// ==== rtl/masked_bfu_top.sv ====
`timescale 1ns/1ps
`include "mbfu_consts.svh"

module masked_bfu_top import mbfu_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               cfg_we_i,
    input  logic [1:0]         cfg_addr_i,
    input  logic [31:0]        cfg_wdata_i,
    output logic [31:0]        cfg_rdata_o,
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  logic [`MBFU_W-1:0] u0_i,
    input  logic [`MBFU_W-1:0] u1_i,
    input  logic [`MBFU_W-1:0] v0_i,
    input  logic [`MBFU_W-1:0] v1_i,
    input  logic [`MBFU_W-1:0] w0_i,
    input  logic [`MBFU_W-1:0] w1_i,
    output logic               out_valid_o,
    input  logic               out_ready_i,
    output logic [`MBFU_W-1:0] u0_o,
    output logic [`MBFU_W-1:0] u1_o,
    output logic [`MBFU_W-1:0] v0_o,
    output logic [`MBFU_W-1:0] v1_o
);

    bfu_ctrl_t                ctrl;
    logic [31:0]              seed;
    logic                     seed_load;
    logic                     zeroize;
    logic                     advance;
    logic [2:0][`MBFU_W-1:0]  rnd;

    bfu_op_if  op_if ();
    bfu_res_if res_if ();

    // operand side, plain ports onto the stream
    assign op_if.valid = in_valid_i;
    assign op_if.u.s0  = u0_i;
    assign op_if.u.s1  = u1_i;
    assign op_if.v.s0  = v0_i;
    assign op_if.v.s1  = v1_i;
    assign op_if.w.s0  = w0_i;
    assign op_if.w.s1  = w1_i;
    assign in_ready_o  = op_if.ready;

    // result side
    assign res_if.ready = out_ready_i;
    assign out_valid_o  = res_if.valid;
    assign u0_o         = res_if.u.s0;
    assign u1_o         = res_if.u.s1;
    assign v0_o         = res_if.v.s0;
    assign v1_o         = res_if.v.s1;

    bfu_ctrl_regs u_regs (
        .clk(clk), .reset_n(reset_n), .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_o(cfg_rdata_o), .ctrl_o(ctrl),
        .seed_o(seed), .seed_load_o(seed_load), .zeroize_o(zeroize)
    );

    // masks move only with the pipe
    mask_rnd_gen u_rnd (
        .clk(clk), .reset_n(reset_n), .advance_i(advance), .load_i(seed_load),
        .seed_i(seed), .rnd_o(rnd)
    );

    masked_gs_butterfly u_bfu (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize), .ctrl_i(ctrl),
        .op(op_if.snk), .res(res_if.src), .rnd_i(rnd), .advance_o(advance)
    );

endmodule

// ==== rtl/masked_gs_butterfly.sv ====
`timescale 1ns/1ps
`include "mbfu_consts.svh"

module masked_gs_butterfly import mbfu_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize_i,
    input  bfu_ctrl_t               ctrl_i,
    bfu_op_if.snk                   op,
    bfu_res_if.src                  res,
    input  logic [2:0][`MBFU_W-1:0] rnd_i,
    output logic                    advance_o
);

    logic        advance;
    logic        pwm_mode;
    logic        pwm_acc;
    share_pair_t sum_res;
    share_pair_t diff_res;
    share_pair_t w_dly;
    share_pair_t late_in;
    share_pair_t late_dly;
    share_pair_t mul_a;
    share_pair_t mul_b;
    share_pair_t mul_res;
    share_pair_t prod_dly;
    share_pair_t acc_res;
    logic        valid_q;

    assign pwm_mode = (ctrl_i.mode == pwm);
    assign pwm_acc  = pwm_mode && ctrl_i.accumulate;

    // whole pipe holds while a result is stuck at the output
    assign advance   = !valid_q || res.ready;
    assign advance_o = advance;
    assign op.ready  = advance;

    // u + v, stage 2
    masked_add_sub u_add (
        .clk(clk), .reset_n(reset_n), .en_i(advance), .zeroize_i(zeroize_i),
        .sub_i(1'b0), .a_i(op.u), .b_i(op.v), .rnd_i(rnd_i[0]), .res_o(sum_res)
    );

    // u - v, stage 2
    masked_add_sub u_sub (
        .clk(clk), .reset_n(reset_n), .en_i(advance), .zeroize_i(zeroize_i),
        .sub_i(1'b1), .a_i(op.u), .b_i(op.v), .rnd_i(rnd_i[1]), .res_o(diff_res)
    );

    // twiddle lined up with the difference
    share_delay #(.T(share_pair_t), .N(`MBFU_ADDSUB_LAT)) u_w_dly (
        .clk(clk), .reset_n(reset_n), .en_i(advance), .zeroize_i(zeroize_i),
        .d_i(op.w), .q_o(w_dly)
    );

    // gs: sum waits out the multiplier (stage 6)
    // pwm: adder is idle, so this line carries w to stage 4
    assign late_in = pwm_mode ? op.w : sum_res;

    share_delay #(.T(share_pair_t), .N(`MBFU_MUL_LAT)) u_late_dly (
        .clk(clk), .reset_n(reset_n), .en_i(advance), .zeroize_i(zeroize_i),
        .d_i(late_in), .q_o(late_dly)
    );

    // pwm multiplies raw operands, ends at stage 4
    assign mul_a = pwm_mode ? op.u : diff_res;
    assign mul_b = pwm_mode ? op.v : w_dly;

    masked_mod_mult u_mult (
        .clk(clk), .reset_n(reset_n), .en_i(advance), .zeroize_i(zeroize_i),
        .a_i(mul_a), .b_i(mul_b), .rnd_i(rnd_i[2]), .res_o(mul_res)
    );

    // plain pwm product padded to stage 6
    share_delay #(.T(share_pair_t), .N(`MBFU_ADDSUB_LAT)) u_prod_dly (
        .clk(clk), .reset_n(reset_n), .en_i(advance), .zeroize_i(zeroize_i),
        .d_i(mul_res), .q_o(prod_dly)
    );

    // u*v + w, also stage 6
    masked_add_sub u_acc (
        .clk(clk), .reset_n(reset_n), .en_i(advance), .zeroize_i(zeroize_i),
        .sub_i(1'b0), .a_i(mul_res), .b_i(late_dly), .rnd_i(rnd_i[1]), .res_o(acc_res)
    );

    // one valid bit per operand slot
    share_delay #(.T(logic), .N(`MBFU_LAT)) u_valid_dly (
        .clk(clk), .reset_n(reset_n), .en_i(advance), .zeroize_i(zeroize_i),
        .d_i(op.valid), .q_o(valid_q)
    );

    assign res.valid = valid_q;

    always_comb begin
        if (!pwm_mode) begin
            res.u = late_dly;
            res.v = mul_res;
        end else begin
            res.u = pwm_acc ? acc_res : prod_dly;
            // v unused in pwm
            res.v = '0;
        end
    end

endmodule

// ==== rtl/masked_mod_mult.sv ====
`timescale 1ns/1ps
`include "mbfu_consts.svh"

module masked_mod_mult import mbfu_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               en_i,
    input  logic               zeroize_i,
    input  share_pair_t        a_i,
    input  share_pair_t        b_i,
    input  logic [`MBFU_W-1:0] rnd_i,
    output share_pair_t        res_o
);

    localparam int PW = 2 * `MBFU_W;
    // floor(2^48 / q); k = 48 keeps the quotient error below one
    localparam int BARRETT_K = 48;
    localparam logic [25:0] BARRETT_M = 26'd33587228;

    // cross products, index = {a share, b share}
    logic [PW-1:0]      prod_q [4];
    logic [`MBFU_W-1:0] red_q [4];
    logic [`MBFU_W-1:0] mix_q [4];
    share_pair_t        res_q;

    function automatic logic [`MBFU_W-1:0] barrett(input logic [PW-1:0] x);
        logic [PW+25:0]     xm;
        logic [23:0]        qhat;
        logic [PW-1:0]      r_full;
        logic [`MBFU_W:0]   r;
        xm = x * BARRETT_M;
        qhat = xm[PW+25:BARRETT_K];
        // true remainder below 2q, so modular wrap in PW bits is harmless
        r_full = x - qhat * `MBFU_Q;
        r = r_full[`MBFU_W:0];
        if (r >= `MBFU_Q) begin
            r = r - `MBFU_Q;
        end
        return r[`MBFU_W-1:0];
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 4; i++) begin
                prod_q[i] <= '0;
                red_q[i]  <= '0;
                mix_q[i]  <= '0;
            end
            res_q <= '0;
        end else if (zeroize_i) begin
            for (int i = 0; i < 4; i++) begin
                prod_q[i] <= '0;
                red_q[i]  <= '0;
                mix_q[i]  <= '0;
            end
            res_q <= '0;
        end else if (en_i) begin
            // stage 1: raw 46-bit products
            prod_q[0] <= a_i.s0 * b_i.s0;
            prod_q[1] <= a_i.s0 * b_i.s1;
            prod_q[2] <= a_i.s1 * b_i.s0;
            prod_q[3] <= a_i.s1 * b_i.s1;
            // stage 2: reduce each product on its own
            for (int i = 0; i < 4; i++) begin
                red_q[i] <= barrett(prod_q[i]);
            end
            // stage 3: mask the two cross terms before they meet a domain
            mix_q[0] <= red_q[0];
            mix_q[1] <= add_mod(red_q[1], rnd_i);
            mix_q[2] <= sub_mod(red_q[2], rnd_i);
            mix_q[3] <= red_q[3];
            // stage 4: domain 0 gets a0b0 + a0b1, domain 1 gets a1b0 + a1b1
            res_q.s0 <= add_mod(mix_q[0], mix_q[1]);
            res_q.s1 <= add_mod(mix_q[2], mix_q[3]);
        end
    end

    assign res_o = res_q;

endmodule

// ==== rtl/mbfu_consts.svh ====
`ifndef MBFU_CONSTS_SVH
`define MBFU_CONSTS_SVH

// ml-dsa prime, 2^23 - 2^13 + 1
`define MBFU_Q 23'd8380417
// one arithmetic share
`define MBFU_W 23

// stage counts of the arithmetic blocks
`define MBFU_ADDSUB_LAT 2
`define MBFU_MUL_LAT 4
// sub (2) + mult (4), same in both modes
`define MBFU_LAT 6

// config register map
`define MBFU_REG_CTRL 2'd0
`define MBFU_REG_SEED 2'd1
`define MBFU_REG_ZEROIZE 2'd2

// fallback when software writes a zero seed
`define MBFU_SEED_DEFAULT 32'h2545_F491

`endif

// ==== rtl/mbfu_pkg.sv ====
`include "mbfu_consts.svh"

package mbfu_pkg;

    // value = (s0 + s1) mod q
    typedef struct packed {
        logic [`MBFU_W-1:0] s0;
        logic [`MBFU_W-1:0] s1;
    } share_pair_t;

    typedef enum logic {
        gs  = 1'b0,
        pwm = 1'b1
    } bfu_mode_t;

    typedef struct packed {
        bfu_mode_t mode;
        logic      accumulate;
    } bfu_ctrl_t;

    // operands below q, one conditional correction
    function automatic logic [`MBFU_W-1:0] add_mod(input logic [`MBFU_W-1:0] a,
                                                   input logic [`MBFU_W-1:0] b);
        logic [`MBFU_W:0] s;
        s = a + b;
        if (s >= `MBFU_Q) begin
            s = s - `MBFU_Q;
        end
        return s[`MBFU_W-1:0];
    endfunction

    function automatic logic [`MBFU_W-1:0] sub_mod(input logic [`MBFU_W-1:0] a,
                                                   input logic [`MBFU_W-1:0] b);
        logic [`MBFU_W:0] d;
        // wrap by adding q back when a < b
        d = (a >= b) ? {1'b0, a} - b : {1'b0, a} + `MBFU_Q - b;
        return d[`MBFU_W-1:0];
    endfunction

endpackage

// ==== rtl/share_delay.sv ====
`timescale 1ns/1ps

module share_delay import mbfu_pkg::*; #(
    parameter type T = share_pair_t,
    parameter int  N = 2
) (
    input  logic clk,
    input  logic reset_n,
    input  logic en_i,
    input  logic zeroize_i,
    input  T     d_i,
    output T     q_o
);

    T dly_q [N];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < N; i++) begin
                dly_q[i] <= '0;
            end
        end else if (zeroize_i) begin
            for (int i = 0; i < N; i++) begin
                dly_q[i] <= '0;
            end
        end else if (en_i) begin
            // shifts only when the pipe advances
            dly_q[0] <= d_i;
            for (int i = 1; i < N; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    assign q_o = dly_q[N-1];

endmodule
